// File: design/banked_memory.sv
/*
 * Four bank word memory behind the cache.
 * Consecutive words sit in consecutive banks. Each accepted access keeps
 * its bank busy for a few cycles, and stall reports the addressed bank.
 * Read data returns after a fixed latency through a short pipeline.
 */
`timescale 1ns/1ps
`include "mem_defines.svh"

module banked_memory (
   input  logic      clk,
   input  logic      reset,
   mem_port_if.mem   port
);
   localparam int BANKS  = `WORDS_PER_LINE;
   localparam int BANK_W = $clog2(BANKS);
   localparam int ROW_W  = `ADDR_W - BANK_W - 1;
   localparam int ROWS   = 2 ** ROW_W;
   localparam int BUSY_W = $clog2(`BANK_BUSY_CYCLES + 1);
   localparam int LAT    = `MEM_RD_LATENCY;

   logic [`DATA_W-1:0]  bank_mem [BANKS][ROWS];
   logic [BUSY_W-1:0]   busy_cnt [BANKS];
   logic [`DATA_W-1:0]  rd_pipe  [LAT];
   logic [LAT-1:0]      rv_pipe;
   logic [BANK_W-1:0]   sel_bank;
   logic [ROW_W-1:0]    sel_row;
   logic                accept;

   // Fixed fill pattern from the word address
   initial begin
      for (int b = 0; b < BANKS; b++) begin
         for (int r = 0; r < ROWS; r++) begin
            bank_mem[b][r] = `DATA_W'(r * BANKS + b) ^ `MEM_INIT_KEY;
         end
      end
   end

   assign sel_bank   = port.addr.bank_v.bank;
   assign sel_row    = port.addr.bank_v.row;
   assign port.stall = (busy_cnt[sel_bank] != '0);
   assign accept     = (port.rd || port.wr) && !port.stall;

   ////////////////////////////////////////////////////////////
   // Bank busy timers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int b = 0; b < BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < BANKS; b++) begin
            if (accept && sel_bank == BANK_W'(b)) begin
               busy_cnt[b] <= BUSY_W'(`BANK_BUSY_CYCLES);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Storage and read pipeline
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (accept && port.wr) begin
         bank_mem[sel_bank][sel_row] <= port.wdata;
      end
      rd_pipe[0] <= bank_mem[sel_bank][sel_row];
      for (int s = 1; s < LAT; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

   // Valid bit rides alongside the data
   always_ff @(posedge clk) begin
      if (reset) begin
         rv_pipe <= '0;
      end else begin
         rv_pipe <= (rv_pipe << 1) | LAT'(accept && port.rd);
      end
   end

   assign port.rdata  = rd_pipe[LAT-1];
   assign port.rvalid = rv_pipe[LAT-1];

   a_single_strobe: assert property (@(posedge clk) disable iff (reset)
      !(port.rd && port.wr));
   a_rvalid_from_read: assert property (@(posedge clk) disable iff (reset)
      port.rvalid |-> $past(accept && port.rd, LAT));

endmodule

// File: design/cache_array.sv
/*
 * Direct mapped cache storage with tag, valid, dirty and line data.
 * Status and read data follow addr in the same cycle. A compare write
 * lands only on a hit and marks the line dirty. A fill write (comp low)
 * stores the tag, loads valid from valid_in and clears dirty.
 */
`timescale 1ns/1ps
`include "mem_defines.svh"

module cache_array (
   input  logic         clk,
   input  logic         reset,
   cache_port_if.array  port
);
   localparam int LINES  = 2 ** `INDEX_W;
   localparam int WORD_W = $clog2(`WORDS_PER_LINE);

   // Per line storage
   logic [`TAG_W-1:0]    tag_q  [LINES];
   logic [`DATA_W-1:0]   data_q [LINES][`WORDS_PER_LINE];
   logic [LINES-1:0]     valid_q;
   logic [LINES-1:0]     dirty_q;

   logic [`INDEX_W-1:0]  idx;
   logic [WORD_W-1:0]    word;
   logic                 tag_match;
   logic                 wr_en;

   ////////////////////////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////////////////////////
   assign idx  = port.addr.cache_v.index;
   assign word = port.addr.cache_v.word;

   // Stored tag against requested tag
   assign tag_match    = (tag_q[idx] == port.addr.cache_v.tag);
   assign port.hit     = port.enable && valid_q[idx] && tag_match;
   assign port.dirty   = dirty_q[idx];
   assign port.tag_out = tag_q[idx];
   assign port.rdata   = data_q[idx][word];

   // Compare write needs a hit, fill write always lands
   assign wr_en = port.enable && port.write && (!port.comp || port.hit);

   ////////////////////////////////////////////////////////////
   // Update
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (wr_en) begin
         data_q[idx][word] <= port.wdata;
         // Fill brings in the new owner of the line
         if (!port.comp) begin
            tag_q[idx] <= port.addr.cache_v.tag;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (wr_en) begin
         if (port.comp) begin
            dirty_q[idx] <= 1'b1;
         end else begin
            valid_q[idx] <= port.valid_in;
            dirty_q[idx] <= 1'b0;
         end
      end
   end

   // Controller never writes without enabling the array
   a_write_enabled: assert property (@(posedge clk) disable iff (reset)
      port.write |-> port.enable);

endmodule

// File: design/cache_controller.sv
/*
 * Cache controller FSM.
 * Latches each request, looks it up, writes back a dirty victim line,
 * refills the line from the banked memory and then finishes the read or
 * merges the write. Misaligned or double strobes end in an err pulse.
 */
`timescale 1ns/1ps
`include "mem_defines.svh"

module cache_controller (
   input  logic                clk,
   input  logic                reset,
   input  logic [`ADDR_W-1:0]  addr,
   input  logic [`DATA_W-1:0]  data_in,
   input  logic                rd,
   input  logic                wr,
   output logic [`DATA_W-1:0]  data_out,
   output logic                done,
   output logic                stall,
   output logic                cache_hit,
   output logic                err,
   cache_port_if.ctrl          cache,
   mem_port_if.ctrl            mem
);
   localparam int WORD_W = $clog2(`WORDS_PER_LINE);
   localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(`WORDS_PER_LINE - 1);

   mem_pkg::ctrl_state_e  state, state_nxt;
   mem_pkg::addr_u        req_addr, beat_addr, ret_addr, victim_addr;
   logic [`DATA_W-1:0]    req_data;
   logic                  req_write;
   logic [WORD_W:0]       beat_cnt;   // Issued memory strobes
   logic [WORD_W-1:0]     ret_cnt;    // Refill words returned
   logic                  mem_accept;
   logic                  bad_req;

   assign bad_req    = addr[0] || (rd && wr);
   assign mem_accept = (mem.rd || mem.wr) && !mem.stall;
   assign stall      = (state != mem_pkg::IDLE);

   // Request payload, taken once per request
   always_ff @(posedge clk) begin
      if (state == mem_pkg::IDLE && (rd || wr)) begin
         req_addr  <= addr;
         req_data  <= data_in;
         req_write <= wr;
      end
   end

   // Word addresses within the requested line
   always_comb begin
      beat_addr               = req_addr;
      beat_addr.cache_v.word  = beat_cnt[WORD_W-1:0];
      ret_addr                = req_addr;
      ret_addr.cache_v.word   = ret_cnt;
      victim_addr             = beat_addr;
      victim_addr.cache_v.tag = cache.tag_out;
   end

   ////////////////////////////////////////////////////////////
   // FSM and counters
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= mem_pkg::IDLE;
         beat_cnt <= '0;
         ret_cnt  <= '0;
      end else begin
         state <= state_nxt;
         if (mem_accept) begin
            // Last victim write restarts the count for the refill reads
            if (state == mem_pkg::EVICT && beat_cnt[WORD_W-1:0] == LAST_WORD)
               beat_cnt <= '0;
            else
               beat_cnt <= beat_cnt + 1'b1;
         end else if (state == mem_pkg::IDLE) begin
            beat_cnt <= '0;
         end
         if (state == mem_pkg::REFILL && mem.rvalid) begin
            ret_cnt <= ret_cnt + 1'b1;
         end
      end
   end

   always_comb begin
      state_nxt      = state;
      done           = 1'b0;
      err            = 1'b0;
      cache_hit      = 1'b0;
      data_out       = '0;
      cache.enable   = 1'b0;
      cache.comp     = 1'b0;
      cache.write    = 1'b0;
      cache.valid_in = 1'b0;
      cache.addr     = req_addr;
      cache.wdata    = req_data;
      mem.rd         = 1'b0;
      mem.wr         = 1'b0;
      mem.addr       = beat_addr;
      mem.wdata      = cache.rdata;
      case (state)
         mem_pkg::IDLE: begin
            if (rd || wr) begin
               if (bad_req)  state_nxt = mem_pkg::ERROR_DONE;
               else if (wr)  state_nxt = mem_pkg::WR_LOOKUP;
               else          state_nxt = mem_pkg::RD_LOOKUP;
            end
         end
         mem_pkg::RD_LOOKUP, mem_pkg::WR_LOOKUP: begin
            cache.enable = 1'b1;
            cache.comp   = 1'b1;
            cache.write  = (state == mem_pkg::WR_LOOKUP);
            if (cache.hit) begin
               // Write hit merges right here
               done      = (state == mem_pkg::WR_LOOKUP);
               cache_hit = (state == mem_pkg::WR_LOOKUP);
               state_nxt = (state == mem_pkg::WR_LOOKUP) ? mem_pkg::IDLE : mem_pkg::RD_HIT;
            end else begin
               state_nxt = cache.dirty ? mem_pkg::EVICT : mem_pkg::REFILL;
            end
         end
         mem_pkg::RD_HIT, mem_pkg::FINISH_RD: begin
            cache.enable = 1'b1;
            cache.comp   = 1'b1;
            done         = 1'b1;
            cache_hit    = (state == mem_pkg::RD_HIT);
            data_out     = cache.rdata;
            state_nxt    = mem_pkg::IDLE;
         end
         mem_pkg::EVICT: begin
            // Victim word read from the array goes straight to memory
            cache.enable = 1'b1;
            cache.addr   = beat_addr;
            mem.wr       = 1'b1;
            mem.addr     = victim_addr;
            if (mem_accept && beat_cnt[WORD_W-1:0] == LAST_WORD)
               state_nxt = mem_pkg::REFILL;
         end
         mem_pkg::REFILL: begin
            mem.rd         = !beat_cnt[WORD_W];
            cache.enable   = mem.rvalid;
            cache.write    = mem.rvalid;
            cache.addr     = ret_addr;
            cache.wdata    = mem.rdata;
            // Line turns valid with its last word
            cache.valid_in = (ret_cnt == LAST_WORD);
            if (mem.rvalid && ret_cnt == LAST_WORD)
               state_nxt = req_write ? mem_pkg::FINISH_WR : mem_pkg::FINISH_RD;
         end
         mem_pkg::FINISH_WR: begin
            cache.enable = 1'b1;
            cache.comp   = 1'b1;
            cache.write  = 1'b1;
            done         = 1'b1;
            state_nxt    = mem_pkg::IDLE;
         end
         mem_pkg::ERROR_DONE: begin
            done      = 1'b1;
            err       = 1'b1;
            state_nxt = mem_pkg::IDLE;
         end
         default: state_nxt = mem_pkg::IDLE;
      endcase
   end

   a_done_pulse: assert property (@(posedge clk) disable iff (reset)
      done |=> !done);
   a_state_legal: assert property (@(posedge clk) disable iff (reset)
      state inside {mem_pkg::IDLE, mem_pkg::RD_LOOKUP, mem_pkg::RD_HIT,
                    mem_pkg::WR_LOOKUP, mem_pkg::EVICT, mem_pkg::REFILL,
                    mem_pkg::FINISH_RD, mem_pkg::FINISH_WR, mem_pkg::ERROR_DONE});

endmodule

// File: design/cache_port_if.sv
/*
 * Connection between the cache controller and the cache array.
 * The controller side drives the access, the array side answers with
 * data and line status combinationally from addr.
 */
`timescale 1ns/1ps
`include "mem_defines.svh"

interface cache_port_if;
   // Access from the controller
   logic                 enable;
   logic                 comp;
   logic                 write;
   logic                 valid_in;
   mem_pkg::addr_u       addr;
   logic [`DATA_W-1:0]   wdata;

   // Line status from the array
   logic [`DATA_W-1:0]   rdata;
   logic                 hit;
   logic                 dirty;
   logic [`TAG_W-1:0]    tag_out;

   modport ctrl  (output enable, comp, write, valid_in, addr, wdata,
                  input  rdata, hit, dirty, tag_out);
   modport array (input  enable, comp, write, valid_in, addr, wdata,
                  output rdata, hit, dirty, tag_out);
endinterface

// File: design/mem_defines.svh
/*
 * Widths, cache geometry and main memory timing for the memory subsystem.
 * Included by the package, the interfaces and every RTL module that sizes
 * a signal or a counter from these values.
 */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Address and word widths
`define ADDR_W            16
`define DATA_W            16

// Direct mapped cache geometry
`define TAG_W             5
`define INDEX_W           8
`define WORDS_PER_LINE    4

// Banked memory timing
`define MEM_RD_LATENCY    2
`define BANK_BUSY_CYCLES  4
`define MEM_INIT_KEY      16'h5A3C

`endif

// File: design/mem_pkg.sv
/*
 * Shared types for the memory subsystem.
 * addr_u decodes one byte address either as tag/index/word for the cache
 * or as row/bank for the banked memory. ctrl_state_e is the cache
 * controller FSM encoding.
 */
`include "mem_defines.svh"

package mem_pkg;

   // Same 16 bits seen two ways, word and bank share bits [2:1]
   typedef union packed {
      struct packed {
         logic [`TAG_W-1:0]                   tag;
         logic [`INDEX_W-1:0]                 index;
         logic [$clog2(`WORDS_PER_LINE)-1:0]  word;
         logic                                byte_sel;
      } cache_v;
      struct packed {
         logic [`ADDR_W-$clog2(`WORDS_PER_LINE)-2:0] row;
         logic [$clog2(`WORDS_PER_LINE)-1:0]         bank;
         logic                                       byte_sel;
      } bank_v;
   } addr_u;

   // Controller FSM states
   typedef enum logic [3:0] {
      IDLE,
      RD_LOOKUP,
      RD_HIT,
      WR_LOOKUP,
      EVICT,
      REFILL,
      FINISH_RD,
      FINISH_WR,
      ERROR_DONE
   } ctrl_state_e;

endpackage

// File: design/mem_port_if.sv
/*
 * Connection between the cache controller and the banked memory.
 * Strobes count only in a cycle with stall low.
 */
`timescale 1ns/1ps
`include "mem_defines.svh"

interface mem_port_if;
   // Strobes and payload from the controller
   logic                 rd;
   logic                 wr;
   mem_pkg::addr_u       addr;
   logic [`DATA_W-1:0]   wdata;

   // Returned data and back-pressure
   logic [`DATA_W-1:0]   rdata;
   logic                 rvalid;
   logic                 stall;

   modport ctrl (output rd, wr, addr, wdata, input  rdata, rvalid, stall);
   modport mem  (input  rd, wr, addr, wdata, output rdata, rvalid, stall);
endinterface

// File: design/mem_system.sv
/*
 * Top level of the memory subsystem.
 * The controller sits between the processor strobes and two independent
 * blocks, the cache array and the banked main memory.
 */
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_system (
   input  logic                clk,
   input  logic                reset,
   input  logic [`ADDR_W-1:0]  addr,
   input  logic [`DATA_W-1:0]  data_in,
   input  logic                rd,
   input  logic                wr,
   output logic [`DATA_W-1:0]  data_out,
   output logic                done,
   output logic                stall,
   output logic                cache_hit,
   output logic                err
);
   // Controller to array and controller to memory links
   cache_port_if cache_if ();
   mem_port_if   mem_if ();

   cache_controller u_cache_controller (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err),
      .cache     (cache_if.ctrl),
      .mem       (mem_if.ctrl)
   );

   cache_array u_cache_array (
      .clk   (clk),
      .reset (reset),
      .port  (cache_if.array)
   );

   banked_memory u_banked_memory (
      .clk   (clk),
      .reset (reset),
      .port  (mem_if.mem)
   );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the memory subsystem testbench with Verilator, run it into a log
# and decide pass or fail from the log contents.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f tb.f --top-module tb_mem_system \
   -Mdir "$OBJ" -o sim_mem_system
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/sim_mem_system" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tb.f
+incdir+design
design/mem_pkg.sv
design/cache_port_if.sv
design/mem_port_if.sv
design/cache_array.sv
design/banked_memory.sv
design/cache_controller.sv
design/mem_system.sv
verification/tb_mem_system.sv

// File: verification/tb_mem_system.sv
/*
 * Directed testbench for the cache and banked memory subsystem.
 * A shadow memory and a shadow tag table predict data_out and cache_hit
 * for every request. Each test task drives requests through one shared
 * access task and prints one line when it finishes.
 */
`timescale 1ns/1ps
`include "mem_defines.svh"

module tb_mem_system;
   localparam int RESET_CYCLES = 16;
   localparam int DONE_LIMIT   = 40;
   localparam int RAND_OPS     = 60;
   // 2 + 3 + 3 + 4 + 3 directed requests plus the random ones
   localparam int NUM_REQUESTS = 15 + RAND_OPS;
   localparam logic [15:0] INIT_KEY = 16'h5A3C;

   logic        clk;
   logic        reset;
   logic [15:0] addr;
   logic [15:0] data_in;
   logic        rd;
   logic        wr;
   logic [15:0] data_out;
   logic        done;
   logic        stall;
   logic        cache_hit;
   logic        err;

   // Shadow memory, only written words are stored
   logic [15:0]  shadow [logic [14:0]];
   logic [4:0]   shadow_tag [256];
   logic [255:0] shadow_valid = '0;
   logic [15:0]  lfsr_q = 16'd35;
   int           errors = 0;
   int           checks = 0;
   int           tests  = 0;

   mem_system u_mem_system (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Hang guard sized from the request count
   initial begin
      repeat (NUM_REQUESTS * DONE_LIMIT + RESET_CYCLES + 10) @(posedge clk);
      $display("Watchdog expired before the tests finished");
      $display("Result: FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////
   function automatic logic [15:0] make_addr(input logic [4:0] tag,
                                             input logic [7:0] index,
                                             input logic [1:0] word);
      return {tag, index, word, 1'b0};
   endfunction

   // Unwritten words follow the fill rule on the word address
   function automatic logic [15:0] model_word(input logic [15:0] a);
      logic [14:0] w;
      w = a[15:1];
      if (shadow.exists(w)) return shadow[w];
      return {1'b0, w} ^ INIT_KEY;
   endfunction

   function automatic logic expect_hit(input logic [15:0] a);
      return shadow_valid[a[10:3]] && (shadow_tag[a[10:3]] == a[15:11]);
   endfunction

   // Any completed good access leaves its line resident
   function automatic void note_line(input logic [15:0] a);
      shadow_valid[a[10:3]] = 1'b1;
      shadow_tag[a[10:3]]   = a[15:11];
   endfunction

   // Galois LFSR, one step per bit taken
   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
         v = {v[14:0], lfsr_q[0]};
      end
      return v;
   endfunction

   task automatic check(input string name, input logic [15:0] got,
                        input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH %s got=%h expected=%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic report_test(input string name, input int base);
      tests++;
      $display("%s: %0d errors", name, errors - base);
   endtask

   ////////////////////////////////////////////////////////////
   // Request driving
   ////////////////////////////////////////////////////////////
   // One strobe cycle, then wait for done with a bound
   task automatic access(input logic rd_v, input logic wr_v, input logic [15:0] a,
                         input logic [15:0] d, output logic [15:0] q,
                         output logic hit, output logic e);
      int waited;
      waited = 0;
      q      = '0;
      hit    = 1'b0;
      e      = 1'b0;
      @(posedge clk);
      #5;
      while (stall) begin
         @(posedge clk);
         #5;
      end
      addr    = a;
      data_in = d;
      rd      = rd_v;
      wr      = wr_v;
      @(posedge clk);
      #5;
      rd = 1'b0;
      wr = 1'b0;
      while (!done && waited < DONE_LIMIT) begin
         @(posedge clk);
         #5;
         waited++;
      end
      if (!done) begin
         errors++;
         $display("No done within %0d cycles for request at address %h", DONE_LIMIT, a);
      end else begin
         q   = data_out;
         hit = cache_hit;
         e   = err;
         // Busy level covers the done cycle too
         check("stall", 16'(stall), 16'h0001);
      end
   endtask

   task automatic read_word(input logic [15:0] a);
      logic [15:0] q;
      logic        hit;
      logic        e;
      logic        exp_hit;
      exp_hit = expect_hit(a);
      access(1'b1, 1'b0, a, 16'h0000, q, hit, e);
      check("data_out", q, model_word(a));
      check("cache_hit", 16'(hit), 16'(exp_hit));
      check("err", 16'(e), 16'h0000);
      note_line(a);
   endtask

   task automatic write_word(input logic [15:0] a, input logic [15:0] d);
      logic [15:0] q;
      logic        hit;
      logic        e;
      logic        exp_hit;
      exp_hit = expect_hit(a);
      access(1'b0, 1'b1, a, d, q, hit, e);
      check("cache_hit", 16'(hit), 16'(exp_hit));
      check("err", 16'(e), 16'h0000);
      shadow[a[15:1]] = d;
      note_line(a);
   endtask

   // Rejected request, model stays as it is
   task automatic bad_request(input logic rd_v, input logic wr_v, input logic [15:0] a);
      logic [15:0] q;
      logic        hit;
      logic        e;
      access(rd_v, wr_v, a, 16'hDEAD, q, hit, e);
      check("err", 16'(e), 16'h0001);
      check("cache_hit", 16'(hit), 16'h0000);
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////
   task automatic test_reset_state();
      int base;
      base = errors;
      check("done", 16'(done), 16'h0000);
      check("err", 16'(err), 16'h0000);
      check("cache_hit", 16'(cache_hit), 16'h0000);
      check("stall", 16'(stall), 16'h0000);
      report_test("reset_state", base);
   endtask

   task automatic test_cold_read_miss();
      int base;
      logic [15:0] a;
      base = errors;
      a = make_addr(5'd1, 8'h10, 2'd2);
      read_word(a);
      read_word(a);
      report_test("cold_read_miss", base);
   endtask

   task automatic test_write_hit();
      int base;
      logic [15:0] a;
      base = errors;
      a = make_addr(5'd2, 8'h11, 2'd1);
      read_word(a);
      write_word(a, 16'hC0DE);
      read_word(a);
      report_test("write_hit", base);
   endtask

   // Same index, different tags, so the dirty line goes back to memory
   task automatic test_dirty_eviction();
      int base;
      logic [15:0] a;
      logic [15:0] b;
      base = errors;
      a = make_addr(5'd3, 8'h20, 2'd1);
      b = make_addr(5'd6, 8'h20, 2'd3);
      write_word(a, 16'h1234);
      read_word(b);
      read_word(a);
      report_test("dirty_eviction", base);
   endtask

   task automatic test_write_miss_allocate();
      int base;
      base = errors;
      write_word(make_addr(5'd4, 8'h40, 2'd2), 16'hBEEF);
      read_word(make_addr(5'd4, 8'h40, 2'd0));
      read_word(make_addr(5'd4, 8'h40, 2'd1));
      read_word(make_addr(5'd4, 8'h40, 2'd3));
      report_test("write_miss_allocate", base);
   endtask

   task automatic test_error_requests();
      int base;
      logic [15:0] a;
      base = errors;
      a = make_addr(5'd5, 8'h41, 2'd0);
      bad_request(1'b1, 1'b0, a | 16'h0001);
      bad_request(1'b1, 1'b1, a);
      read_word(a);
      report_test("error_requests", base);
   endtask

   // Two tag bits and eight lines keep conflicts frequent
   task automatic test_random_traffic();
      int base;
      logic [15:0] op;
      logic [15:0] t;
      logic [15:0] x;
      logic [15:0] w;
      logic [15:0] a;
      base = errors;
      for (int i = 0; i < RAND_OPS; i++) begin
         op = take_bits(1);
         t  = take_bits(2);
         x  = take_bits(3);
         w  = take_bits(2);
         a  = make_addr({3'b000, t[1:0]}, {5'b00000, x[2:0]}, w[1:0]);
         if (op[0]) begin
            write_word(a, take_bits(16));
         end else begin
            read_word(a);
         end
      end
      report_test("random_traffic", base);
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////
   initial begin
      reset   = 1'b1;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #5;
      reset = 1'b0;
      test_reset_state();
      test_cold_read_miss();
      test_write_hit();
      test_dirty_eviction();
      test_write_miss_allocate();
      test_error_requests();
      test_random_traffic();
      $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule
